//--- hw/iob_cache_macros.svh
`ifndef IOB_CACHE_MACROS_SVH
`define IOB_CACHE_MACROS_SVH

// front-end port widths
`define FE_ADDR_W     16                        // byte address
`define FE_DATA_W     32                        // one word
`define FE_NBYTES     (`FE_DATA_W/8)
`define FE_BYTE_W     ($clog2(`FE_NBYTES))      // byte offset bits

// cache geometry
`define LINE_OFF_W    4                         // 16 lines
`define WORD_OFF_W    2                         // 4 words per line
`define WTBUF_DEPTH_W 2                         // 4 pending writes

// derived address fields
`define WORD_ADDR_W   (`FE_ADDR_W-`FE_BYTE_W)
`define LINE_ADDR_W   (`WORD_ADDR_W-`WORD_OFF_W)
`define TAG_W         (`LINE_ADDR_W-`LINE_OFF_W)

`endif

//--- hw/iob_cache_pkg.sv
`default_nettype none
`include "iob_cache_macros.svh"

package iob_cache_pkg;

   typedef logic [`FE_ADDR_W-1:0]   fe_addr_t;     // byte address
   typedef logic [`WORD_ADDR_W-1:0] word_addr_t;   // byte bits dropped
   typedef logic [`LINE_ADDR_W-1:0] line_addr_t;   // tag and index only
   typedef logic [`FE_DATA_W-1:0]   data_t;
   typedef logic [`FE_NBYTES-1:0]   wstrb_t;       // one bit per byte
   typedef logic [`TAG_W-1:0]       tag_t;
   typedef logic [`LINE_OFF_W-1:0]  index_t;
   typedef logic [`WORD_OFF_W-1:0]  word_off_t;

   // cache memory controller
   typedef enum logic [2:0]
   {
      cs_idle,
      cs_lookup,
      cs_wait_drain,   // buffer empties before any fill
      cs_refill,
      cs_reread
   } cache_state_t;

   // back-end sequencer
   typedef enum logic [1:0]
   {
      be_idle,
      be_write,
      be_fill
   } be_state_t;

endpackage

`default_nettype wire

//--- hw/write_through_buffer.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module write_through_buffer
(
   input  wire logic                      clk,
   input  wire logic                      reset,
   // from the lookup stage
   input  wire logic                      push,
   input  wire iob_cache_pkg::word_addr_t push_addr,
   input  wire iob_cache_pkg::data_t      push_data,
   input  wire iob_cache_pkg::wstrb_t     push_strb,
   // from the back end
   input  wire logic                      pop,
   output iob_cache_pkg::word_addr_t      head_addr,
   output iob_cache_pkg::data_t           head_data,
   output iob_cache_pkg::wstrb_t          head_strb,
   output logic                           full,
   output logic                           empty
);
   import iob_cache_pkg::*;

   localparam int DEPTH = 2**`WTBUF_DEPTH_W;

   word_addr_t                addr_q [DEPTH];
   data_t                     data_q [DEPTH];
   wstrb_t                    strb_q [DEPTH];
   logic [`WTBUF_DEPTH_W-1:0] wr_ptr;
   logic [`WTBUF_DEPTH_W-1:0] rd_ptr;
   logic [`WTBUF_DEPTH_W:0]   count;        // 0 to DEPTH entries

   // entry storage
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         addr_q[wr_ptr] <= push_addr;
         data_q[wr_ptr] <= push_data;
         strb_q[wr_ptr] <= push_strb;
      end
   end

   // pointers wrap on their own
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // both or neither
         endcase
      end
   end

   assign head_addr = addr_q[rd_ptr];
   assign head_data = data_q[rd_ptr];
   assign head_strb = strb_q[rd_ptr];
   assign full      = count[`WTBUF_DEPTH_W];   // msb only at DEPTH
   assign empty     = (count == '0);

endmodule

`default_nettype wire

//--- hw/front_end.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module front_end
(
   input  wire logic                      clk,
   input  wire logic                      reset,
   // master port
   input  wire logic                      valid,
   input  wire iob_cache_pkg::fe_addr_t   addr,
   input  wire iob_cache_pkg::data_t      wdata,
   input  wire iob_cache_pkg::wstrb_t     wstrb,
   output iob_cache_pkg::data_t           rdata,
   output logic                           ready,
   // array read address, only on the accepting cycle
   output logic                           data_valid,
   output iob_cache_pkg::word_addr_t      data_addr,
   // registered request for the lookup stage
   output logic                           data_valid_reg,
   output iob_cache_pkg::word_addr_t      data_addr_reg,
   output iob_cache_pkg::data_t           data_wdata_reg,
   output iob_cache_pkg::wstrb_t          data_wstrb_reg,
   // answer from cache memory
   input  wire iob_cache_pkg::data_t      data_rdata,
   input  wire logic                      data_ready
);

   // one request at a time
   // the master still holds the old request during its ready cycle
   assign data_valid = valid & ~data_valid_reg;
   assign data_addr  = addr[`FE_ADDR_W-1:`FE_BYTE_W];   // word address

   always_ff @(posedge clk)
   begin
      if (reset)
         data_valid_reg <= 1'b0;
      else if (data_valid)
         data_valid_reg <= 1'b1;          // pending from next cycle
      else if (data_ready)
         data_valid_reg <= 1'b0;          // answered
   end

   // request payload, stable until data_ready
   always_ff @(posedge clk)
   begin
      if (data_valid)
      begin
         data_addr_reg  <= data_addr;
         data_wdata_reg <= wdata;
         data_wstrb_reg <= wstrb;         // zero for a read
      end
   end

   // rdata only meaningful with ready on a read
   assign rdata = data_rdata;
   assign ready = data_valid_reg & data_ready;

endmodule

`default_nettype wire

//--- hw/cache_memory.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module cache_memory
(
   input  wire logic                      clk,
   input  wire logic                      reset,
   // accepting cycle
   input  wire logic                      valid,
   input  wire iob_cache_pkg::line_addr_t addr,
   output iob_cache_pkg::data_t           data_rdata,
   output logic                           data_ready,
   // registered request
   input  wire logic                      valid_reg,
   input  wire iob_cache_pkg::word_addr_t addr_reg,
   input  wire iob_cache_pkg::data_t      wdata_reg,
   input  wire iob_cache_pkg::wstrb_t     wstrb_reg,
   // write channel toward the back end
   output logic                           write_valid,
   output iob_cache_pkg::word_addr_t      write_addr,
   output iob_cache_pkg::data_t           write_wdata,
   output iob_cache_pkg::wstrb_t          write_wstrb,
   input  wire logic                      write_ready,
   // read channel for line fills
   output logic                           replace_valid,
   output iob_cache_pkg::line_addr_t      replace_addr,
   input  wire logic                      replace_ready,
   input  wire logic                      read_valid,
   input  wire iob_cache_pkg::word_off_t  read_addr,
   input  wire iob_cache_pkg::data_t      read_rdata
);
   import iob_cache_pkg::*;

   localparam int N_LINES = 2**`LINE_OFF_W;
   localparam int N_WORDS = 2**`WORD_OFF_W;

   tag_t               tag_mem [N_LINES];
   logic [N_LINES-1:0] line_vld;                    // one valid bit per line
   data_t              data_mem [N_LINES*N_WORDS];
   data_t              line_rd [N_WORDS];           // registered line read

   tag_t               req_tag;
   index_t             req_idx;
   word_off_t          req_off;
   index_t             rd_idx;
   logic               rd_en;
   logic               hit;
   logic               is_write;
   logic               line_done;

   logic               wtb_push;
   logic               wtb_full;
   logic               wtb_empty;

   logic               refill_we;
   logic               mem_we;
   word_off_t          wr_off;
   data_t              wr_data;
   data_t              merged;

   cache_state_t       state;
   cache_state_t       state_nxt;

   assign {req_tag, req_idx, req_off} = addr_reg;
   assign is_write  = |wstrb_reg;
   assign hit       = line_vld[req_idx] && (tag_mem[req_idx] == req_tag);
   assign line_done = (state == cs_refill) && replace_ready;

   ////////////////////////////////////////////////////////////
   // controller
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= cs_idle;
      else
         state <= state_nxt;
   end

   always_comb
   begin
      state_nxt  = state;
      data_ready = 1'b0;
      wtb_push   = 1'b0;
      case (state)
         cs_idle:
            if (valid)
               state_nxt = cs_lookup;      // arrays read at this edge
         cs_lookup:
            if (valid_reg)
            begin
               if (is_write)
               begin
                  // write through, hit or miss alike
                  if (!wtb_full)
                  begin
                     wtb_push   = 1'b1;
                     data_ready = 1'b1;
                     state_nxt  = cs_idle;
                  end
               end
               else if (hit)
               begin
                  data_ready = 1'b1;
                  state_nxt  = cs_idle;
               end
               else
                  state_nxt = cs_wait_drain;
            end
         cs_wait_drain:
            if (wtb_empty)
               state_nxt = cs_refill;      // memory now up to date
         cs_refill:
            if (replace_ready)
               state_nxt = cs_reread;
         cs_reread:
            state_nxt = cs_lookup;         // hits on the new line
         default:
            state_nxt = cs_idle;
      endcase
   end

   assign replace_valid = (state == cs_refill);   // held until replace_ready
   assign replace_addr  = {req_tag, req_idx};

   ////////////////////////////////////////////////////////////
   // tag and valid arrays
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (reset)
         line_vld <= '0;                  // whole cache invalid
      else if (line_done)
         line_vld[req_idx] <= 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (line_done)
         tag_mem[req_idx] <= req_tag;
   end

   ////////////////////////////////////////////////////////////
   // data array
   ////////////////////////////////////////////////////////////

   // stored word with the strobed bytes replaced
   always_comb
   begin
      for (int b = 0; b < `FE_NBYTES; b++)
         merged[8*b +: 8] = wstrb_reg[b] ? wdata_reg[8*b +: 8] : line_rd[req_off][8*b +: 8];
   end

   // one write port shared by fills and write hits
   assign refill_we = (state == cs_refill) && read_valid;
   assign mem_we    = refill_we || (wtb_push && hit);   // write miss leaves it alone
   assign wr_off    = refill_we ? read_addr : req_off;
   assign wr_data   = refill_we ? read_rdata : merged;

   // read on acceptance, again after a fill
   assign rd_en  = valid || (state == cs_reread);
   assign rd_idx = (state == cs_reread) ? req_idx : addr[`LINE_OFF_W-1:0];

   always_ff @(posedge clk)
   begin
      if (mem_we)
         data_mem[{req_idx, wr_off}] <= wr_data;
      if (rd_en)
         for (int w = 0; w < N_WORDS; w++)
            line_rd[w] <= data_mem[{rd_idx, word_off_t'(w)}];
   end

   assign data_rdata = line_rd[req_off];

   ////////////////////////////////////////////////////////////
   // write-through buffer
   ////////////////////////////////////////////////////////////

   write_through_buffer wtbuf
   (
      .clk       (clk),
      .reset     (reset),
      .push      (wtb_push),
      .push_addr (addr_reg),
      .push_data (wdata_reg),
      .push_strb (wstrb_reg),
      .pop       (write_ready),          // memory took the head
      .head_addr (write_addr),
      .head_data (write_wdata),
      .head_strb (write_wstrb),
      .full      (wtb_full),
      .empty     (wtb_empty)
   );

   assign write_valid = ~wtb_empty;

endmodule

`default_nettype wire

//--- hw/back_end_native.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module back_end_native
(
   input  wire logic                      clk,
   input  wire logic                      reset,
   // write channel
   input  wire logic                      write_valid,
   input  wire iob_cache_pkg::word_addr_t write_addr,
   input  wire iob_cache_pkg::data_t      write_wdata,
   input  wire iob_cache_pkg::wstrb_t     write_wstrb,
   output logic                           write_ready,
   // read channel
   input  wire logic                      replace_valid,
   input  wire iob_cache_pkg::line_addr_t replace_addr,
   output logic                           replace_ready,
   output logic                           read_valid,
   output iob_cache_pkg::word_off_t       read_addr,
   output iob_cache_pkg::data_t           read_rdata,
   // native memory port
   output logic                           mem_valid,
   output iob_cache_pkg::fe_addr_t        mem_addr,
   output iob_cache_pkg::data_t           mem_wdata,
   output iob_cache_pkg::wstrb_t          mem_wstrb,
   input  wire iob_cache_pkg::data_t      mem_rdata,
   input  wire logic                      mem_ready
);
   import iob_cache_pkg::*;

   be_state_t state;
   be_state_t state_nxt;
   word_off_t word_cnt;                    // fill word in flight
   logic      last_word;

   assign last_word = &word_cnt;

   ////////////////////////////////////////////////////////////
   // sequencer
   ////////////////////////////////////////////////////////////

   always_comb
   begin
      state_nxt     = state;
      mem_valid     = 1'b0;
      mem_addr      = {write_addr, {`FE_BYTE_W{1'b0}}};
      mem_wstrb     = '0;                  // read unless writing
      write_ready   = 1'b0;
      read_valid    = 1'b0;
      replace_ready = 1'b0;
      case (state)
         be_idle:
            if (replace_valid)             // fill wins a tie
               state_nxt = be_fill;
            else if (write_valid)
               state_nxt = be_write;
         be_write:
         begin
            mem_valid   = 1'b1;            // held until mem_ready
            mem_wstrb   = write_wstrb;
            write_ready = mem_ready;        // pops the buffer head
            if (mem_ready)
               state_nxt = be_idle;
         end
         be_fill:
         begin
            mem_valid     = 1'b1;
            mem_addr      = {replace_addr, word_cnt, {`FE_BYTE_W{1'b0}}};
            read_valid    = mem_ready;     // one word per accepted read
            replace_ready = mem_ready && last_word;
            if (mem_ready && last_word)
               state_nxt = be_idle;
         end
         default:
            state_nxt = be_idle;
      endcase
   end

   assign mem_wdata  = write_wdata;        // ignored on reads
   assign read_addr  = word_cnt;
   assign read_rdata = mem_rdata;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state    <= be_idle;
         word_cnt <= '0;
      end
      else
      begin
         state <= state_nxt;
         if (state == be_idle)
            word_cnt <= '0;                // fills start at offset 0
         else if (read_valid)
            word_cnt <= word_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- hw/iob_cache.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module iob_cache
(
   input  wire logic                      clk,
   input  wire logic                      reset,
   // master port
   input  wire logic                      valid,
   input  wire iob_cache_pkg::fe_addr_t   addr,
   input  wire iob_cache_pkg::data_t      wdata,
   input  wire iob_cache_pkg::wstrb_t     wstrb,
   output iob_cache_pkg::data_t           rdata,
   output logic                           ready,
   // memory port
   output logic                           mem_valid,
   output iob_cache_pkg::fe_addr_t        mem_addr,
   output iob_cache_pkg::data_t           mem_wdata,
   output iob_cache_pkg::wstrb_t          mem_wstrb,
   input  wire iob_cache_pkg::data_t      mem_rdata,
   input  wire logic                      mem_ready
);
   import iob_cache_pkg::*;

   // front end to cache memory
   logic       data_valid;
   word_addr_t data_addr;
   logic       data_valid_reg;
   word_addr_t data_addr_reg;
   data_t      data_wdata_reg;
   wstrb_t     data_wstrb_reg;
   data_t      data_rdata;
   logic       data_ready;

   // write channel
   logic       write_valid;
   word_addr_t write_addr;
   data_t      write_wdata;
   wstrb_t     write_wstrb;
   logic       write_ready;

   // read channel
   logic       replace_valid;
   line_addr_t replace_addr;
   logic       replace_ready;
   logic       read_valid;
   word_off_t  read_addr;
   data_t      read_rdata;

   ////////////////////////////////////////////////////////////
   // stages
   ////////////////////////////////////////////////////////////

   front_end front_end
   (
      .clk            (clk),
      .reset          (reset),
      .valid          (valid),
      .addr           (addr),
      .wdata          (wdata),
      .wstrb          (wstrb),
      .rdata          (rdata),
      .ready          (ready),
      .data_valid     (data_valid),
      .data_addr      (data_addr),
      .data_valid_reg (data_valid_reg),
      .data_addr_reg  (data_addr_reg),
      .data_wdata_reg (data_wdata_reg),
      .data_wstrb_reg (data_wstrb_reg),
      .data_rdata     (data_rdata),
      .data_ready     (data_ready)
   );

   cache_memory cache_memory
   (
      .clk           (clk),
      .reset         (reset),
      .valid         (data_valid),
      .addr          (data_addr[`WORD_ADDR_W-1:`WORD_OFF_W]),   // line address
      .data_rdata    (data_rdata),
      .data_ready    (data_ready),
      .valid_reg     (data_valid_reg),
      .addr_reg      (data_addr_reg),
      .wdata_reg     (data_wdata_reg),
      .wstrb_reg     (data_wstrb_reg),
      .write_valid   (write_valid),
      .write_addr    (write_addr),
      .write_wdata   (write_wdata),
      .write_wstrb   (write_wstrb),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata)
   );

   back_end_native back_end
   (
      .clk           (clk),
      .reset         (reset),
      .write_valid   (write_valid),
      .write_addr    (write_addr),
      .write_wdata   (write_wdata),
      .write_wstrb   (write_wstrb),
      .write_ready   (write_ready),
      .replace_valid (replace_valid),
      .replace_addr  (replace_addr),
      .replace_ready (replace_ready),
      .read_valid    (read_valid),
      .read_addr     (read_addr),
      .read_rdata    (read_rdata),
      .mem_valid     (mem_valid),
      .mem_addr      (mem_addr),
      .mem_wdata     (mem_wdata),
      .mem_wstrb     (mem_wstrb),
      .mem_rdata     (mem_rdata),
      .mem_ready     (mem_ready)
   );

endmodule

`default_nettype wire

//--- verif/tb_mem.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module tb_mem
(
   input  wire logic                    clk,
   input  wire logic                    reset,
   input  wire logic [7:0]              stall,      // wait cycles for the next access
   // native memory port
   input  wire logic                    mem_valid,
   input  wire iob_cache_pkg::fe_addr_t mem_addr,
   input  wire iob_cache_pkg::data_t    mem_wdata,
   input  wire iob_cache_pkg::wstrb_t   mem_wstrb,
   output iob_cache_pkg::data_t         mem_rdata,
   output logic                         mem_ready
);
   import iob_cache_pkg::*;

   localparam int N_WORDS = 2**`WORD_ADDR_W;      // whole address space

   data_t      mem [N_WORDS];
   word_addr_t waddr;
   data_t      merged;
   logic       busy;                              // access in progress
   logic [7:0] wait_cnt;

   assign waddr = mem_addr[`FE_ADDR_W-1:`FE_BYTE_W];

   // address xor constant, replicated
   initial
   begin
      for (int w = 0; w < N_WORDS; w++)
         mem[w] = {2{16'(w) ^ 16'h5a3c}};
   end

   // stored word under the strobes
   always_comb
   begin
      for (int b = 0; b < `FE_NBYTES; b++)
         merged[8*b +: 8] = mem_wstrb[b] ? mem_wdata[8*b +: 8] : mem[waddr][8*b +: 8];
   end

   always @(posedge clk)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         mem_ready <= 1'b0;
         mem_rdata <= '0;
         wait_cnt  <= '0;
      end
      else if (mem_ready)
      begin
         mem_ready <= 1'b0;                       // one-cycle pulse
         busy      <= 1'b0;
      end
      else if (!busy)
      begin
         if (mem_valid)
         begin
            busy     <= 1'b1;
            wait_cnt <= stall;                    // latched per access
         end
      end
      else if (wait_cnt != 8'd0)
         wait_cnt <= wait_cnt - 8'd1;
      else
      begin
         mem_ready <= 1'b1;
         mem_rdata <= mem[waddr];
         if (mem_wstrb != '0)
            mem[waddr] <= merged;
      end
   end

endmodule

`default_nettype wire

//--- verif/iob_cache_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "iob_cache_macros.svh"

module iob_cache_tb;
   import iob_cache_pkg::*;

   localparam int REQ_TIMEOUT   = 2000;           // cycles per request
   localparam int DRAIN_TIMEOUT = 4000;
   localparam int N_WORDS       = 2**`WORD_ADDR_W;

   typedef struct packed
   {
      fe_addr_t a;
      data_t    d;
      wstrb_t   s;
   } wr_t;

   logic        clk;
   logic        reset;
   logic        valid;
   fe_addr_t    addr;
   data_t       wdata;
   wstrb_t      wstrb;
   data_t       rdata;
   logic        ready;
   logic        mem_valid;
   fe_addr_t    mem_addr;
   data_t       mem_wdata;
   wstrb_t      mem_wstrb;
   data_t       mem_rdata;
   logic        mem_ready;
   logic [7:0]  stall;

   logic [31:0] rng;
   logic [7:0]  stall_max;                        // stalls drawn in 0..stall_max
   data_t       shadow [N_WORDS];                 // expected memory content
   wr_t         wq [$];                           // issued writes, oldest first
   int          errors;
   int          tests_run;
   int          tests_failed;
   logic        timed_out;

   iob_cache uut
   (
      .clk       (clk),
      .reset     (reset),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .rdata     (rdata),
      .ready     (ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   tb_mem memory
   (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   always #20 clk = ~clk;                         // 40 ns period

   ////////////////////////////////////////////////////////////
   // model and helpers
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic data_t initial_word(input word_addr_t w);
      return {2{16'(w) ^ 16'h5a3c}};              // same rule as the memory
   endfunction

   function automatic word_addr_t word_of(input fe_addr_t a);
      return a[`FE_ADDR_W-1:`FE_BYTE_W];
   endfunction

   function automatic data_t merge_bytes(input data_t old, input data_t wd, input wstrb_t ws);
      data_t res;
      res = old;
      for (int b = 0; b < `FE_NBYTES; b++)
         if (ws[b])
            res[8*b +: 8] = wd[8*b +: 8];
      return res;
   endfunction

   task automatic draw(output logic [31:0] value);
      rng   = xorshift(rng);
      value = rng;
   endtask

   // one cycle, fresh stall for the memory
   task automatic tick();
      logic [31:0] r;
      @(negedge clk);
      draw(r);
      stall = 8'(r % (32'(stall_max) + 32'd1));
   endtask

   // 4 tags over indices 0..7
   task automatic random_addr(output fe_addr_t a);
      logic [31:0] r;
      draw(r);
      a = {tag_t'(8'h40 + 8'(r[1:0]) * 8'h11), index_t'(r[4:2]), word_off_t'(r[6:5]), 2'b00};
   endtask

   task automatic report_mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_flag(input string name, input logic got, input logic expected);
      if (got !== expected)
         report_mismatch($sformatf("%s is %b, expected %b", name, got, expected));
   endtask

   task automatic check_rdata(input fe_addr_t a, input data_t got, input data_t expected);
      if (got !== expected)
         report_mismatch($sformatf("read %h returned %h, expected %h", a, got, expected));
   endtask

   task automatic check_mem_write(input fe_addr_t a, input data_t d, input wstrb_t s);
      wr_t expected;
      if (wq.size() == 0)
      begin
         $display("error at %0t: memory write to %h with no write pending", $time, a);
         errors++;
      end
      else
      begin
         expected = wq.pop_front();               // write-through keeps order
         if (a !== expected.a || d !== expected.d || s !== expected.s)
            report_mismatch($sformatf("memory write %h %h %h, expected %h %h %h",
                                      a, d, s, expected.a, expected.d, expected.s));
      end
   endtask

   // one master request, lat counts cycles from acceptance to ready
   task automatic access(input fe_addr_t a, input data_t wd, input wstrb_t ws,
                         output data_t rd, output int lat);
      int  cycles;
      wr_t entry;
      cycles = 0;
      rd     = '0;
      lat    = 0;
      if (!timed_out)
      begin
         tick();
         valid = 1'b1;
         addr  = a;
         wdata = wd;
         wstrb = ws;
         tick();
         cycles = 1;
         while (!ready && cycles < REQ_TIMEOUT)
         begin
            tick();
            cycles++;
         end
         if (!ready)
         begin
            $display("timeout at %0t: no ready for the request to %h", $time, a);
            errors++;
            timed_out = 1'b1;
         end
         else
         begin
            rd = rdata;
            if (ws != '0)
            begin
               shadow[word_of(a)] = merge_bytes(shadow[word_of(a)], wd, ws);
               entry.a = a;
               entry.d = wd;
               entry.s = ws;
               wq.push_back(entry);
            end
         end
         valid = 1'b0;
         wstrb = '0;
         lat   = cycles;
      end
   endtask

   task automatic random_write(output fe_addr_t a);
      logic [31:0] r;
      wstrb_t      ws;
      data_t       rd;
      int          lat;
      random_addr(a);
      draw(r);
      ws = wstrb_t'(r[3:0]);
      if (ws == '0)
         ws = '1;                                 // zero strobe means read
      draw(r);
      access(a, r, ws, rd, lat);
   endtask

   task automatic read_and_check(input fe_addr_t a, output int lat);
      data_t rd;
      access(a, '0, '0, rd, lat);
      if (!timed_out)
         check_rdata(a, rd, shadow[word_of(a)]);
   endtask

   // every issued write must reach the memory port
   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (wq.size() != 0 && cycles < DRAIN_TIMEOUT)
      begin
         tick();
         cycles++;
      end
      if (wq.size() != 0)
      begin
         $display("timeout at %0t: %0d writes never reached memory", $time, wq.size());
         errors++;
         timed_out = 1'b1;
      end
   endtask

   task automatic finish_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before)
         $display("test %s: ok", name);
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   // write traffic at the memory port
   always @(negedge clk)
   begin
      if (!reset && mem_valid && mem_ready && (mem_wstrb != '0))
         check_mem_write(mem_addr, mem_wdata, mem_wstrb);
   end

   ////////////////////////////////////////////////////////////
   // tests
   ////////////////////////////////////////////////////////////

   initial
   begin : stimulus
      fe_addr_t    a;
      fe_addr_t    b;
      fe_addr_t    burst [6];
      data_t       rd;
      int          lat;
      int          e0;
      logic [31:0] r;

      clk          = 1'b0;
      reset        = 1'b1;
      valid        = 1'b0;
      addr         = '0;
      wdata        = '0;
      wstrb        = '0;
      stall        = '0;
      rng          = 32'd29390;
      stall_max    = 8'd3;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      for (int w = 0; w < N_WORDS; w++)
         shadow[w] = initial_word(word_addr_t'(w));

      tick();
      tick();                                     // 2 reset cycles
      reset = 1'b0;
      tick();

      // fresh reads, then a hit of 1 cycle
      e0 = errors;
      check_flag("ready after reset", ready, 1'b0);
      check_flag("mem_valid after reset", mem_valid, 1'b0);
      for (int i = 0; i < 8; i++)
      begin
         random_addr(a);
         read_and_check(a, lat);
         read_and_check(a, lat);
         if (!timed_out && lat != 1)
            report_mismatch($sformatf("read hit %h took %0d cycles, expected 1", a, lat));
      end
      finish_test("reset and fresh reads", e0);

      e0 = errors;
      for (int i = 0; i < 40; i++)
      begin
         random_write(a);
         read_and_check(a, lat);
         random_addr(b);
         read_and_check(b, lat);
      end
      finish_test("random writes and reads", e0);

      // tag 0xf0 is never cached here
      e0 = errors;
      for (int i = 0; i < 8; i++)
      begin
         random_write(a);
         draw(r);
         a = {8'hf0, index_t'(i), 2'b01, 2'b00};
         access(a, r, wstrb_t'(4'hf ^ i[3:0]), rd, lat);   // write miss
      end
      wait_drain();
      for (int i = 0; i < 8; i++)
         read_and_check({8'hf0, index_t'(i), 2'b01, 2'b00}, lat);
      finish_test("write-through order", e0);

      // two tags fighting over one index
      e0 = errors;
      for (int k = 0; k < 4; k++)
      begin
         draw(r);
         a = {8'h40, index_t'(r[2:0]), word_off_t'(r[4:3]), 2'b00};
         b = {8'h51, a[7:0]};
         for (int j = 0; j < 6; j++)
         begin
            if (j == 2)
            begin
               draw(r);
               access(b, r, wstrb_t'(r[7:4]) | 4'b0001, rd, lat);
            end
            read_and_check(a, lat);
            read_and_check(b, lat);
         end
      end
      finish_test("conflict eviction", e0);

      // slow memory, bursts deeper than the buffer
      e0 = errors;
      stall_max = 8'd24;
      for (int k = 0; k < 4; k++)
      begin
         for (int j = 0; j < 6; j++)
            random_write(burst[j]);
         for (int j = 0; j < 6; j++)
            read_and_check(burst[j], lat);
      end
      wait_drain();
      stall_max = 8'd3;
      finish_test("back-pressure", e0);

      wait_drain();
      $display("tests: %0d passed, %0d failed, %0d errors",
               tests_run - tests_failed, tests_failed, errors);
      if (errors == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- iob_cache.f
+incdir+hw
hw/iob_cache_pkg.sv
hw/write_through_buffer.sv
hw/front_end.sv
hw/cache_memory.sv
hw/back_end_native.sv
hw/iob_cache.sv
verif/tb_mem.sv
verif/iob_cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= iob_cache_tb
FILELIST  ?= iob_cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal -j 0
SOURCES   := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
